// File: rtl/squeeze_cfg_pkg.sv
//////////////////////////////////////////////////
// Layer dimensions and numeric formats of the 1x1
// squeeze layer, shared by every RTL block
//////////////////////////////////////////////////

package squeeze_cfg_pkg;

	//////////////////////////////////////////////////
	// Layer dimensions
	//////////////////////////////////////////////////

	// Output channels computed side by side
	localparam int LANES = 4;
	// Input channels per pixel, serial
	localparam int CHIN = 8;
	// 4x4 output map
	localparam int OUT_PIXELS = 16;

	//////////////////////////////////////////////////
	// Numeric formats
	//////////////////////////////////////////////////

	// Requantization shift back to activation scale
	localparam int FRAC_SHIFT = 14;

	// Activation, sign bit zero after ReLU
	typedef logic [15:0] act_t;
	// Signed kernel weight
	typedef logic signed [15:0] weight_t;
	// Accumulator, wide enough for CHIN products
	typedef logic signed [31:0] acc_t;
	// Channel index inside one pixel
	typedef logic [2:0] chan_t;
	// Finished pixel count, reaches OUT_PIXELS
	typedef logic [4:0] pix_cnt_t;

endpackage

// File: rtl/squeeze_ctrl_pkg.sv
//////////////////////////////////////////////////
// Control state and the packed records passed
// between counter, weight ROM and MAC lanes
//////////////////////////////////////////////////

package squeeze_ctrl_pkg;

	// Layer progress
	typedef enum logic [1:0] {
		LAYER_RUN,
		LAYER_DONE,
		LAYER_RELEASED
	} layer_state_e;

	// One accepted input, counter to ROM stage
	typedef struct packed {
		logic valid;
		squeeze_cfg_pkg::chan_t chan;
		logic first;
		logic last;
		squeeze_cfg_pkg::act_t act;
	} chan_step_t;

	// One operand, ROM stage to a single lane
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		squeeze_cfg_pkg::act_t act;
		squeeze_cfg_pkg::weight_t weight;
	} lane_op_t;

	// Output pixel, slot i is output channel i
	typedef squeeze_cfg_pkg::act_t [squeeze_cfg_pkg::LANES-1:0] ofm_vec_t;

endpackage

// File: rtl/channel_counter.sv
//////////////////////////////////////////////////
// Input register stage, tags each accepted
// activation with its channel and pixel bounds
//////////////////////////////////////////////////

`timescale 1ns/1ns

module channel_counter (
	input  logic clk,
	input  logic rst,
	input  logic accept_en,
	input  squeeze_cfg_pkg::act_t ifm_i,
	output squeeze_ctrl_pkg::chan_step_t step
);
	import squeeze_cfg_pkg::*;

	// Channel of the next accepted activation
	chan_t chan_cnt;
	logic at_last;

	assign at_last = (chan_cnt == chan_t'(CHIN - 1));

	//////////////////////////////////////////////////
	// Control part, valid strobe and channel count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			step.valid <= 1'b0;
			chan_cnt <= '0;
		end else begin
			step.valid <= accept_en;
			// Idle cycles hold the count
			if (accept_en) begin
				if (at_last)
					chan_cnt <= '0;
				else
					chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Payload part, only loaded on accept
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept_en) begin
			step.chan <= chan_cnt;
			step.first <= (chan_cnt == '0);
			step.last <= at_last;
			step.act <= ifm_i;
		end
	end

endmodule

// File: rtl/squeeze_ctrl.sv
//////////////////////////////////////////////////
// Layer FSM, counts finished pixels, gates input
// and holds finish until the RAM acknowledges
//////////////////////////////////////////////////

`timescale 1ns/1ns

module squeeze_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic pixel_done,
	input  logic ram_ack,
	output logic accept_en,
	output logic finish
);
	import squeeze_cfg_pkg::*;
	import squeeze_ctrl_pkg::*;

	layer_state_e state;
	pix_cnt_t pix_cnt;
	// Ack seen at any time, kept until reset
	logic ack_latched;
	logic last_pixel;

	assign last_pixel = pixel_done && (pix_cnt == pix_cnt_t'(OUT_PIXELS - 1));

	// Input only passes while the layer runs
	assign accept_en = en_i && (state == LAYER_RUN);
	assign finish = (state == LAYER_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_latched <= 1'b0;
		end else if (ram_ack) begin
			ack_latched <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// State and pixel count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LAYER_RUN;
			pix_cnt <= '0;
		end else begin
			case (state)
				LAYER_RUN: begin
					if (pixel_done)
						pix_cnt <= pix_cnt + 1'b1;
					// Sixteenth sample ends the layer
					if (last_pixel)
						state <= LAYER_DONE;
				end
				LAYER_DONE: begin
					if (ram_ack || ack_latched)
						state <= LAYER_RELEASED;
				end
				// Stays here until reset
				LAYER_RELEASED: state <= LAYER_RELEASED;
				default: state <= LAYER_RUN;
			endcase
		end
	end

endmodule

// File: rtl/weight_rom.sv
//////////////////////////////////////////////////
// Constant 1x1 kernel table per channel and lane,
// plus per-lane bias, with a registered read stage
//////////////////////////////////////////////////

`timescale 1ns/1ns

module weight_rom (
	input  logic clk,
	input  logic rst,
	input  squeeze_ctrl_pkg::chan_step_t step,
	output squeeze_ctrl_pkg::lane_op_t [squeeze_cfg_pkg::LANES-1:0] ops,
	output squeeze_cfg_pkg::acc_t [squeeze_cfg_pkg::LANES-1:0] bias
);
	import squeeze_cfg_pkg::*;

	// Weights of the current channel with lane 0 in the low slot
	weight_t [LANES-1:0] w;

	//////////////////////////////////////////////////
	// Weight table listed from lane 3 down to lane 0
	//////////////////////////////////////////////////

	always_comb begin
		case (step.chan)
			3'd0: w = {16'sh0c00, 16'shfa00, 16'sh1000, 16'sh2000};
			3'd1: w = {16'shf000, 16'sh0800, 16'sh0400, 16'shf800};
			3'd2: w = {16'sh0200, 16'sh1400, 16'shfc00, 16'sh1000};
			3'd3: w = {16'sh0600, 16'shf400, 16'sh0a00, 16'sh0400};
			3'd4: w = {16'shfe00, 16'sh0c00, 16'sh0800, 16'shf400};
			3'd5: w = {16'sh1800, 16'shf800, 16'shf600, 16'sh0c00};
			3'd6: w = {16'shf800, 16'sh0400, 16'sh1200, 16'sh0200};
			3'd7: w = {16'sh0400, 16'shfc00, 16'shf000, 16'sh0800};
			default: w = '0;
		endcase
	end

	// Bias at accumulator scale where 1.0 is 1 << FRAC_SHIFT
	// Lane 2 leans negative so it clamps more often
	assign bias = {32'sh0000_2000, 32'shffff_8000, 32'sh0000_4000, 32'sh0000_1000};

	//////////////////////////////////////////////////
	// Read stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			if (rst)
				ops[l].valid <= 1'b0;
			else
				ops[l].valid <= step.valid;
			// Same channel fields fan out to every lane
			if (step.valid) begin
				ops[l].first <= step.first;
				ops[l].last <= step.last;
				ops[l].act <= step.act;
				ops[l].weight <= w[l];
			end
		end
	end

endmodule

// File: rtl/mac_lane.sv
//////////////////////////////////////////////////
// One output channel, accumulates channel products
// then adds bias, applies ReLU and requantizes
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mac_lane (
	input  logic clk,
	input  logic rst,
	input  squeeze_ctrl_pkg::lane_op_t op,
	input  squeeze_cfg_pkg::acc_t bias,
	output squeeze_cfg_pkg::act_t ofm_o,
	output logic done
);
	import squeeze_cfg_pkg::*;

	acc_t acc;
	acc_t prod;
	// Running sum including this cycle's product
	acc_t sum;
	acc_t total;
	logic finish_px;

	assign prod = $signed(op.act) * op.weight;
	// First channel starts a fresh pixel
	assign sum = (op.first ? acc_t'(0) : acc) + prod;
	assign total = sum + bias;
	assign finish_px = op.valid && op.last;

	always_ff @(posedge clk) begin
		if (op.valid)
			acc <= sum;
	end

	// Negative clamps to zero, else bits 28:14 with sign cleared
	always_ff @(posedge clk) begin
		if (finish_px) begin
			if (total[31])
				ofm_o <= '0;
			else
				ofm_o <= {1'b0, total[FRAC_SHIFT+14:FRAC_SHIFT]};
		end
	end

	// One-cycle pulse with the new output
	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= finish_px;
	end

endmodule

// File: rtl/squeeze_top.sv
//////////////////////////////////////////////////
// Squeeze layer top, counter then ROM then lanes,
// with the layer FSM watching lane 0
//////////////////////////////////////////////////

`timescale 1ns/1ns

module squeeze_top (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  squeeze_cfg_pkg::act_t ifm_i,
	input  logic ram_ack,
	output squeeze_ctrl_pkg::ofm_vec_t ofm,
	output logic sample,
	output logic finish
);
	import squeeze_cfg_pkg::*;
	import squeeze_ctrl_pkg::*;

	logic accept_en;
	chan_step_t step;
	lane_op_t [LANES-1:0] ops;
	acc_t [LANES-1:0] bias;
	logic [LANES-1:0] lane_done;

	// All lanes finish together, lane 0 stands for them
	assign sample = lane_done[0];

	squeeze_ctrl squeeze_ctrl_i (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.pixel_done(sample),
		.ram_ack(ram_ack),
		.accept_en(accept_en),
		.finish(finish)
	);

	channel_counter channel_counter_i (
		.clk(clk),
		.rst(rst),
		.accept_en(accept_en),
		.ifm_i(ifm_i),
		.step(step)
	);

	weight_rom weight_rom_i (
		.clk(clk),
		.rst(rst),
		.step(step),
		.ops(ops),
		.bias(bias)
	);

	//////////////////////////////////////////////////
	// MAC lanes, one per output channel
	//////////////////////////////////////////////////

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		mac_lane mac_lane_i (
			.clk(clk),
			.rst(rst),
			.op(ops[g]),
			.bias(bias[g]),
			.ofm_o(ofm[g]),
			.done(lane_done[g])
		);
	end

endmodule

// File: tb/squeeze_sva.sv
//////////////////////////////////////////////////
// Bound checks on sample and finish of the layer
// top level, attached to squeeze_top by bind
//////////////////////////////////////////////////

`timescale 1ns/1ns

module squeeze_sva (
	input logic clk,
	input logic rst,
	input logic sample,
	input logic finish
);
	logic finish_q;
	// Set once finish has fallen
	logic released;
	// Number of failed checks so far
	int fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			finish_q <= 1'b0;
			released <= 1'b0;
		end else begin
			finish_q <= finish;
			if (finish_q && !finish)
				released <= 1'b1;
		end
	end

	// One pulse per output pixel
	sample_pulse: assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
		else begin
			$error("sample high for more than one cycle");
			fail_cnt++;
		end

	// Finish only after the last sample has gone
	sample_finish_excl: assert property (@(posedge clk) disable iff (rst) !(sample && finish))
		else begin
			$error("sample and finish high together");
			fail_cnt++;
		end

	// No second finish without reset
	finish_stays_low: assert property (@(posedge clk) disable iff (rst) released |-> !finish)
		else begin
			$error("finish rose again after it fell");
			fail_cnt++;
		end

endmodule

bind squeeze_top squeeze_sva squeeze_sva_i (
	.clk(clk),
	.rst(rst),
	.sample(sample),
	.finish(finish)
);

// File: tb/squeeze_tb.sv
//////////////////////////////////////////////////
// Trace-driven testbench of the squeeze layer with
// random enable gaps, ofm checks and finish/ack flow
//////////////////////////////////////////////////

`timescale 1ns/1ns

module squeeze_tb;
	import squeeze_cfg_pkg::*;
	import squeeze_ctrl_pkg::*;

	// Eight activations then four expected outputs per trace line
	localparam int LINE_WORDS = CHIN + LANES;
	localparam int TRACE_WORDS = OUT_PIXELS * LINE_WORDS;
	// Up to 4 cycles per activation plus margin
	localparam int TIMEOUT_CYCLES = OUT_PIXELS * CHIN * 4 + 200;

	logic clk;
	logic rst;
	logic en_i;
	act_t ifm_i;
	logic ram_ack;
	ofm_vec_t ofm;
	logic sample;
	logic finish;

	logic [15:0] trace_mem [0:TRACE_WORDS-1];
	int seed = 32'h5427;
	int sample_cnt = 0;
	int cycle_cnt = 0;

	squeeze_top squeeze_top_i (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.ifm_i(ifm_i),
		.ram_ack(ram_ack),
		.ofm(ofm),
		.sample(sample),
		.finish(finish)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Error exits
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic value_mismatch(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		abort_run();
	endtask

	task automatic protocol_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		abort_run();
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// One enable pulse followed by 0 to 3 idle cycles with junk on ifm_i
	task automatic drive_activation(input act_t act);
		int gap;
		en_i = 1'b1;
		ifm_i = act;
		@(posedge clk);
		#1;
		en_i = 1'b0;
		ifm_i = act_t'($random(seed));
		gap = $random(seed) & 3;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drive_pixel(input int px);
		for (int c = 0; c < CHIN; c++)
			drive_activation(trace_mem[px * LINE_WORDS + c]);
	endtask

	// No sample and a fixed finish level for a number of cycles
	task automatic hold_and_check(input int cycles, input logic finish_exp);
		repeat (cycles) begin
			@(negedge clk);
			assert (sample == 1'b0) else value_mismatch("sample", 16'(sample), 16'h0);
			assert (finish == finish_exp)
				else value_mismatch("finish", 16'(finish), 16'(finish_exp));
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Output monitor sampling mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		int base;
		assert (squeeze_top_i.squeeze_sva_i.fail_cnt == 0)
			else protocol_error("a bound assertion on sample or finish failed");
		if (!rst) begin
			if (sample_cnt < OUT_PIXELS)
				assert (finish == 1'b0) else protocol_error("finish high before the last pixel");
			if (sample && sample_cnt >= OUT_PIXELS) begin
				protocol_error("sample seen after the last pixel");
			end else if (sample) begin
				base = sample_cnt * LINE_WORDS + CHIN;
				for (int l = 0; l < LANES; l++)
					assert (ofm[l] == trace_mem[base + l])
						else value_mismatch($sformatf("ofm[%0d]", l), ofm[l], trace_mem[base + l]);
				sample_cnt++;
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES)
			protocol_error("timeout, the layer did not complete within the cycle limit");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		en_i = 1'b0;
		ifm_i = '0;
		ram_ack = 1'b0;
		$readmemh("tb/squeeze_trace.txt", trace_mem);
		assert (!$isunknown(trace_mem[TRACE_WORDS-1]))
			else protocol_error("trace file missing or too short");
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Quiet outputs before any input
		hold_and_check(4, 1'b0);

		for (int px = 0; px < OUT_PIXELS; px++)
			drive_pixel(px);

		// Drain the pipeline and expect finish one cycle after the last sample
		while (sample_cnt < OUT_PIXELS)
			@(posedge clk);
		@(negedge clk);
		assert (finish == 1'b1) else value_mismatch("finish", 16'(finish), 16'h1);
		@(posedge clk);
		#1;

		// Input after the layer is over must be dropped
		for (int c = 0; c < 2 * CHIN; c++)
			drive_activation(act_t'(16'h0100 + c));
		hold_and_check(6, 1'b1);

		// Ack pulse releases finish on the next edge
		ram_ack = 1'b1;
		@(negedge clk);
		assert (finish == 1'b1) else value_mismatch("finish", 16'(finish), 16'h1);
		@(posedge clk);
		#1;
		ram_ack = 1'b0;
		hold_and_check(20, 1'b0);

		if (squeeze_top_i.squeeze_sva_i.fail_cnt != 0) begin
			protocol_error("a bound assertion on sample or finish failed");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: squeeze.f
rtl/squeeze_cfg_pkg.sv
rtl/squeeze_ctrl_pkg.sv
rtl/channel_counter.sv
rtl/squeeze_ctrl.sv
rtl/weight_rom.sv
rtl/mac_lane.sv
rtl/squeeze_top.sv
tb/squeeze_sva.sv
tb/squeeze_tb.sv

// File: tb/squeeze_trace.txt
// ch0 ch1 ch2 ch3 ch4 ch5 ch6 ch7 input activations, then expected ofm lane 0 to lane 3
// one output pixel per line, all words hex
0100 0000 0000 0000 0000 0000 0000 0000 0080 0041 0000 0030
0000 0100 0000 0000 0000 0000 0000 0000 0000 0011 001e 0000
0000 0000 0080 0000 0000 0000 0000 0000 0020 0000 0026 0004
0000 0000 0000 0200 0000 0000 0000 0000 0020 0051 0000 0030
0000 0000 0000 0000 0100 0000 0000 0000 0000 0021 002e 0000
0000 0000 0000 0000 0000 0100 0000 0000 0030 0000 0000 0060
0000 0000 0000 0000 0000 0000 0100 0100 0028 0009 0000 0000
0040 0040 0040 0040 0040 0040 0040 0040 0036 001b 000c 0016
0100 0100 0100 0100 0100 0100 0100 0100 00d8 0069 0036 0058
0010 0020 0030 0040 0050 0060 0070 0080 002a 0008 0005 001e
0080 0070 0060 0050 0040 0030 0020 0010 004f 0034 0016 0014
0000 0200 0000 0000 0200 0000 0000 0200 0000 0000 007e 0000
1000 0000 0000 0000 0000 0000 0000 0000 0800 0401 0000 0300
0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000
0300 0100 0000 0000 0000 0200 0000 0000 01c0 0081 0000 0110
0000 0000 0100 0100 0000 0000 0200 0000 0060 00a9 003e 0000
